// ==== bench/clockGen.sv ====
module clockGen (
	output logic clk,
	output logic arstN
);

	// Free running clock, 100 time units per period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset held for 16 cycles and released away from the rising edge
	initial begin
		arstN = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
	end

endmodule

// ==== bench/mmuBench.sv ====
`include "mmu_defs.svh"

module mmuBench import mmuPkg::*; ();

	localparam int maxLines = 64;
	localparam int wordsPerLine = 6;	// Opcode plus five arguments
	localparam int randomOps = 200;

	logic clk;
	logic arstN;
	cfgWriteT cfg;
	logic selWe;
	selT selData;
	logic enterUser;
	logic enterKernel;
	addrT imAddr;
	addrT dmAddr;
	logic faultClear;
	xlatResultT imResult;
	xlatResultT dmResult;
	faultRecordT faultRec;

	logic [31:0] pat [0:maxLines*wordsPerLine-1];	// Pattern file, six words per line
	int numLines;
	bit patternsLoaded;

	// Reference model of the table, selector and mode
	addrT modelLowerIm [`MMU_NUM_PROCS];
	addrT modelUpperIm [`MMU_NUM_PROCS];
	addrT modelLowerDm [`MMU_NUM_PROCS];
	addrT modelUpperDm [`MMU_NUM_PROCS];
	selT modelSel;
	execModeT modelMode;

	xlatResultT expIm;		// Results expected after the next rising edge
	xlatResultT expDm;
	addrT expImLog;			// Logical addresses behind them
	addrT expDmLog;
	faultRecordT expRec;

	bit filePending;		// Pattern line expectations waiting to be checked
	xlatResultT fileIm;
	xlatResultT fileDm;

	clockGen clocks (
		.clk(clk),
		.arstN(arstN)
	);

	mmuTop dut (
		.clk(clk),
		.arstN(arstN),
		.cfg(cfg),
		.selWe(selWe),
		.selData(selData),
		.enterUser(enterUser),
		.enterKernel(enterKernel),
		.imAddr(imAddr),
		.dmAddr(dmAddr),
		.faultClear(faultClear),
		.imResult(imResult),
		.dmResult(dmResult),
		.faultRec(faultRec)
	);

	task automatic checkResult(input string what, input xlatResultT expected,
			input xlatResultT actual);
		if (actual !== expected) begin
			$display("Fail at %0t: %s expected addr %h fault %b, got addr %h fault %b", $time,
				what, expected.physAddr, expected.fault, actual.physAddr, actual.fault);
			$display("TEST FAILED");
			$fatal(1, "Translation result mismatch");
		end
	endtask

	task automatic checkRecord(input string what, input faultRecordT expected,
			input faultRecordT actual);
		if (actual !== expected) begin
			$display("Fail at %0t: %s expected cause %0d addr %h, got cause %0d addr %h", $time,
				what, expected.cause, expected.addr, actual.cause, actual.addr);
			$display("TEST FAILED");
			$fatal(1, "Fault record mismatch");
		end
	endtask

	// Relocation by the stated rule, wide enough that an overflow always lands above upper
	function automatic xlatResultT relocate(input addrT logical, input addrT lower,
			input addrT upper, input execModeT curMode);
		xlatResultT r;
		logic [31:0] wide;
		wide = 32'(logical) + 32'(lower);
		r.physAddr = logical;	// Kernel passes the address through
		r.fault = 1'b0;
		if (curMode == userMode) begin
			r.physAddr = wide[`MMU_ADDR_W-1:0];
			r.fault = wide > 32'(upper);
		end
		return r;
	endfunction

	task automatic idleInputs();
		cfg = '0;
		selWe = 1'b0;
		selData = '0;
		enterUser = 1'b0;
		enterKernel = 1'b0;
		imAddr = '0;
		dmAddr = '0;
		faultClear = 1'b0;
	endtask

	// Advances the model across one rising edge using the inputs now driven
	task automatic stepModel();
		if (expRec.cause == noFault || faultClear) begin	// Recorder sees last edge's results
			if (expIm.fault) begin
				expRec.cause = imBound;
				expRec.addr = expImLog;
			end else if (expDm.fault) begin
				expRec.cause = dmBound;
				expRec.addr = expDmLog;
			end else begin
				expRec = '0;
			end
		end
		expIm = relocate(imAddr, modelLowerIm[modelSel], modelUpperIm[modelSel], modelMode);
		expDm = relocate(dmAddr, modelLowerDm[modelSel], modelUpperDm[modelSel], modelMode);
		expImLog = imAddr;
		expDmLog = dmAddr;
		if (cfg.we) begin
			case (cfg.field)
				lowerIm: modelLowerIm[modelSel] = cfg.data;
				upperIm: modelUpperIm[modelSel] = cfg.data;
				lowerDm: modelLowerDm[modelSel] = cfg.data;
				upperDm: modelUpperDm[modelSel] = cfg.data;
			endcase
		end
		if (selWe)
			modelSel = selData;
		if (enterKernel)
			modelMode = kernelMode;
		else if (enterUser)
			modelMode = userMode;
	endtask

	task automatic checkOutputs();
		checkResult("imResult", expIm, imResult);
		checkResult("dmResult", expDm, dmResult);
		checkRecord("faultRec", expRec, faultRec);
		if (filePending) begin
			checkResult("imResult from pattern line", fileIm, imResult);
			checkResult("dmResult from pattern line", fileDm, dmResult);
			filePending = 1'b0;
		end
	endtask

	task automatic applyPattern(input int base);
		logic [31:0] op;
		logic [31:0] a1;
		logic [31:0] a2;
		faultRecordT fileRec;
		op = pat[base];
		a1 = pat[base+1];
		a2 = pat[base+2];
		case (op)
			32'd1: begin
				cfg.we = 1'b1;
				cfg.field = boundFieldT'(a1[1:0]);
				cfg.data = addrT'(a2);
			end
			32'd2: begin
				selWe = 1'b1;
				selData = selT'(a1);
			end
			32'd3: begin
				enterUser = a1[0];		// 1 enters user mode, 0 enters kernel mode
				enterKernel = !a1[0];
			end
			32'd4: begin
				imAddr = addrT'(a1);
				dmAddr = addrT'(a2);
				fileIm.physAddr = addrT'(pat[base+3]);
				fileIm.fault = pat[base+5][1];
				fileDm.physAddr = addrT'(pat[base+4]);
				fileDm.fault = pat[base+5][0];
				filePending = 1'b1;
			end
			32'd5: begin
				fileRec.cause = faultCauseT'(a1[1:0]);
				fileRec.addr = addrT'(a2);
				checkRecord("faultRec before clear", fileRec, faultRec);
				faultClear = 1'b1;
			end
			default: begin
				$display("Pattern line %0d holds an unknown operation %0d", base / wordsPerLine, op);
				$display("TEST FAILED");
				$fatal(1, "Bad pattern file");
			end
		endcase
	endtask

	task automatic randomOp();
		logic [31:0] pick;
		logic [31:0] value;
		pick = $urandom % 16;
		value = $urandom;
		if (pick < 2) begin
			cfg.we = 1'b1;
			cfg.field = boundFieldT'(value[1:0]);
			cfg.data = value[2] ? addrT'($urandom) : addrT'($urandom % 32'h0040_0000);
		end else if (pick == 2) begin
			selWe = 1'b1;
			selData = selT'($urandom % `MMU_NUM_PROCS);
		end else if (pick == 3) begin
			enterUser = 1'b1;
		end else if (pick == 4) begin
			enterKernel = 1'b1;
		end else begin
			imAddr = value[0] ? addrT'($urandom) : addrT'($urandom % 32'h2000);	// Mostly in range
			dmAddr = value[1] ? addrT'($urandom) : addrT'($urandom % 32'h2000);
			faultClear = value[5:3] == 3'd0;
		end
	endtask

	initial begin : mainFlow
		int seedValue;
		seedValue = $urandom(32'hba07_31aa);
		idleInputs();
		for (int i = 0; i < `MMU_NUM_PROCS; i++) begin	// Table is all zero after reset
			modelLowerIm[i] = '0;
			modelUpperIm[i] = '0;
			modelLowerDm[i] = '0;
			modelUpperDm[i] = '0;
		end
		modelSel = '0;
		modelMode = kernelMode;
		expIm = '0;
		expDm = '0;
		expImLog = '0;
		expDmLog = '0;
		expRec = '0;
		filePending = 1'b0;
		$readmemh("bench/mmu_patterns.txt", pat);
		numLines = 0;
		while (numLines < maxLines && pat[numLines*wordsPerLine] != 32'd0) begin
			numLines++;
		end
		patternsLoaded = 1'b1;
		wait (arstN === 1'b1);
		for (int n = 0; n < numLines; n++) begin
			@(negedge clk);
			checkOutputs();
			idleInputs();
			applyPattern(n * wordsPerLine);
			stepModel();
		end
		for (int n = 0; n < randomOps; n++) begin
			@(negedge clk);
			checkOutputs();
			idleInputs();
			randomOp();
			stepModel();
		end
		@(negedge clk);
		checkOutputs();		// Last sampled operation
		$display("TEST OK");
		$finish;
	end

	// Limit scales with the pattern count plus the random phase
	initial begin : watchdog
		int limit;
		wait (patternsLoaded);
		limit = numLines + randomOps + 1000;
		repeat (limit) @(posedge clk);
		$display("The run timed out after %0d cycles without finishing", limit);
		$display("TEST FAILED");
		$fatal(1, "Watchdog expired");
	end

endmodule

// ==== bench/mmu_patterns.txt ====
// Columns in hex: op a1 a2 a3 a4 a5. op 1 bound write (field, data), 2 selector (value),
// 3 mode (1 user, 0 kernel), 4 translate (im, dm, imPhys, dmPhys, faults im:dm), 5 clear, 0 end
00000004 00000123 00000456 00000123 00000456 00000000
00000004 03ffffff 00000000 03ffffff 00000000 00000000
00000001 00000000 00001000 00000000 00000000 00000000
00000001 00000001 00001fff 00000000 00000000 00000000
00000001 00000002 00100000 00000000 00000000 00000000
00000001 00000003 0010ffff 00000000 00000000 00000000
00000002 00000003 00000000 00000000 00000000 00000000
00000001 00000000 00200000 00000000 00000000 00000000
00000001 00000001 00200fff 00000000 00000000 00000000
00000001 00000002 00300000 00000000 00000000 00000000
00000001 00000003 003000ff 00000000 00000000 00000000
00000002 00000000 00000000 00000000 00000000 00000000
00000003 00000001 00000000 00000000 00000000 00000000
00000004 00000010 00000020 00001010 00100020 00000000
00000004 00000fff 0000ffff 00001fff 0010ffff 00000000
00000002 00000003 00000000 00000000 00000000 00000000
00000004 00000004 00000008 00200004 00300008 00000000
00000004 00000005 00000100 00200005 00300100 00000001
00000004 00001000 00000200 00201000 00300200 00000003
00000005 00000002 00000100 00000000 00000000 00000000
00000005 00000001 00001000 00000000 00000000 00000000
00000004 03ffffff 00000000 001fffff 00300000 00000002
00000004 00000000 00000400 00200000 00300400 00000001
00000004 00000000 00000000 00200000 00300000 00000000
00000005 00000001 03ffffff 00000000 00000000 00000000
00000005 00000000 00000000 00000000 00000000 00000000
00000003 00000000 00000000 00000000 00000000 00000000
00000001 00000000 00210000 00000000 00000000 00000000
00000001 00000001 00210fff 00000000 00000000 00000000
00000002 00000000 00000000 00000000 00000000 00000000
00000003 00000001 00000000 00000000 00000000 00000000
00000004 00000010 00000020 00001010 00100020 00000000
00000002 00000003 00000000 00000000 00000000 00000000
00000004 00000010 00000020 00210010 00300020 00000000
00000003 00000000 00000000 00000000 00000000 00000000
00000004 03ffffff 03ffffff 03ffffff 03ffffff 00000000
00000005 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000

// ==== design/addressTranslator.sv ====
`include "mmu_defs.svh"

module addressTranslator import mmuPkg::*; (
	input logic clk,
	input logic arstN,
	input addrT logicalAddr,		// Address from the processor, new one every cycle
	input segBoundsT bounds,		// Bounds of this memory for the running process
	input execModeT mode,
	output xlatResultT result,		// Physical address and fault, one cycle later
	output addrT sampledAddr		// Logical address that belongs to result
);

	// One extra bit keeps the carry out of the relocation add
	logic [`MMU_ADDR_W:0] relocSum;
	addrT relocAddr;
	logic relocOverflow;
	logic aboveUpper;
	xlatResultT nextResult;

	assign relocSum = {1'b0, logicalAddr} + {1'b0, bounds.lower};
	assign relocAddr = relocSum[`MMU_ADDR_W-1:0];
	assign relocOverflow = relocSum[`MMU_ADDR_W];	// Wrapped past the top of memory

	// An address exactly at the upper bound is still legal
	assign aboveUpper = relocAddr > bounds.upper;

	always_comb begin
		if (mode == userMode) begin
			nextResult.physAddr = relocAddr;
			nextResult.fault = relocOverflow || aboveUpper;
		end else begin
			// Kernel sees the physical memory directly
			nextResult.physAddr = logicalAddr;
			nextResult.fault = 1'b0;
		end
	end

	// Result register
	// Cleared on reset so the memories see address zero with no fault
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			result <= '0;
		end else begin
			result <= nextResult;
		end
	end

	// Logical address kept alongside the result for the fault recorder
	always_ff @(posedge clk) begin
		sampledAddr <= logicalAddr;
	end

	// A sample taken in kernel mode must come out clean on the next edge,
	// whatever the table holds for the selected process
	noKernelFault: assert property (
		@(posedge clk) disable iff (!arstN)
		(mode == kernelMode) |=> !result.fault
	) else $error("Fault raised for an address sampled in kernel mode");

endmodule

// ==== design/faultRecorder.sv ====
`include "mmu_defs.svh"

module faultRecorder import mmuPkg::*; (
	input logic clk,
	input logic arstN,
	input logic imFault,			// Registered fault of the instruction stream
	input logic dmFault,			// Registered fault of the data stream
	input addrT imAddr,				// Logical address behind imFault
	input addrT dmAddr,				// Logical address behind dmFault
	input logic faultClear,			// Single cycle pulse that empties the record
	output faultRecordT faultRec
);

	faultRecordT nextRec;
	logic recEmpty;

	assign recEmpty = faultRec.cause == noFault;

	// Candidate record for this cycle
	// Instruction faults take priority when both streams fault together
	always_comb begin
		if (imFault) begin
			nextRec.cause = imBound;
			nextRec.addr = imAddr;
		end else if (dmFault) begin
			nextRec.cause = dmBound;
			nextRec.addr = dmAddr;
		end else begin
			nextRec.cause = noFault;	// Empty record carries a zero address
			nextRec.addr = '0;
		end
	end

	// The record only moves while it is empty or being cleared
	// A clear in the same cycle as a new fault keeps the new fault
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			faultRec.cause <= noFault;
			faultRec.addr <= '0;
		end else if (recEmpty || faultClear) begin
			faultRec <= nextRec;
		end
	end

	// An empty record never reports a stale address to software
	emptyHasNoAddr: assert property (
		@(posedge clk) disable iff (!arstN)
		(faultRec.cause == noFault) |-> (faultRec.addr == {`MMU_ADDR_W{1'b0}})
	) else $error("Fault record is empty but holds address %h", faultRec.addr);

endmodule

// ==== design/mmuPkg.sv ====
`include "mmu_defs.svh"

package mmuPkg;

	typedef logic [`MMU_ADDR_W-1:0] addrT;	// Logical or physical address
	typedef logic [`MMU_SEL_W-1:0] selT;		// Index of a process entry

	// Which of the four bounds a configuration write lands in
	typedef enum logic [1:0] {
		lowerIm = 2'd0,	// Base of the instruction segment
		upperIm = 2'd1,	// Highest legal instruction address
		lowerDm = 2'd2,	// Base of the data segment
		upperDm = 2'd3	// Highest legal data address
	} boundFieldT;

	// Kernel mode bypasses relocation and checking altogether
	typedef enum logic {
		kernelMode = 1'b0,
		userMode   = 1'b1
	} execModeT;

	// Cause kept by the fault recorder, noFault means the record is empty
	typedef enum logic [1:0] {
		noFault = 2'd0,
		imBound = 2'd1,
		dmBound = 2'd2
	} faultCauseT;

	// Both bounds of one memory for the running process
	typedef struct packed {
		addrT lower;
		addrT upper;
	} segBoundsT;

	// Plain write strobe with its target field and value
	typedef struct packed {
		logic we;
		boundFieldT field;
		addrT data;
	} cfgWriteT;

	// Registered output of a translator
	typedef struct packed {
		addrT physAddr;
		logic fault;
	} xlatResultT;

	// The first fault seen, with the logical address that caused it
	typedef struct packed {
		faultCauseT cause;
		addrT addr;
	} faultRecordT;

endpackage

// ==== design/mmuTop.sv ====
`include "mmu_defs.svh"

module mmuTop import mmuPkg::*; (
	input logic clk,
	input logic arstN,
	input cfgWriteT cfg,
	input logic selWe,
	input selT selData,
	input logic enterUser,
	input logic enterKernel,
	input addrT imAddr,			// Logical instruction address
	input addrT dmAddr,			// Logical data address
	input logic faultClear,
	output xlatResultT imResult,
	output xlatResultT dmResult,
	output faultRecordT faultRec
);

	segBoundsT imBounds;
	segBoundsT dmBounds;
	execModeT mode;
	addrT imSampled;		// Logical addresses aligned with the results
	addrT dmSampled;

	// Per process bounds, selector and mode
	segmentTable segTable (
		.clk(clk),
		.arstN(arstN),
		.cfg(cfg),
		.selWe(selWe),
		.selData(selData),
		.enterUser(enterUser),
		.enterKernel(enterKernel),
		.imBounds(imBounds),
		.dmBounds(dmBounds),
		.mode(mode)
	);

	// Instruction stream
	addressTranslator imXlat (
		.clk(clk),
		.arstN(arstN),
		.logicalAddr(imAddr),
		.bounds(imBounds),
		.mode(mode),
		.result(imResult),
		.sampledAddr(imSampled)
	);

	// Data stream with the same logic and the data bounds
	addressTranslator dmXlat (
		.clk(clk),
		.arstN(arstN),
		.logicalAddr(dmAddr),
		.bounds(dmBounds),
		.mode(mode),
		.result(dmResult),
		.sampledAddr(dmSampled)
	);

	faultRecorder recorder (
		.clk(clk),
		.arstN(arstN),
		.imFault(imResult.fault),
		.dmFault(dmResult.fault),
		.imAddr(imSampled),
		.dmAddr(dmSampled),
		.faultClear(faultClear),
		.faultRec(faultRec)
	);

endmodule

// ==== design/segmentTable.sv ====
`include "mmu_defs.svh"

module segmentTable import mmuPkg::*; (
	input logic clk,
	input logic arstN,
	input cfgWriteT cfg,			// Bound write for the selected process
	input logic selWe,				// Loads selData into the selector
	input selT selData,
	input logic enterUser,			// Single cycle pulse
	input logic enterKernel,		// Single cycle pulse, wins over enterUser
	output segBoundsT imBounds,
	output segBoundsT dmBounds,
	output execModeT mode
);

	// One register per process for each of the four bounds
	addrT lowerImTab [`MMU_NUM_PROCS];
	addrT upperImTab [`MMU_NUM_PROCS];
	addrT lowerDmTab [`MMU_NUM_PROCS];
	addrT upperDmTab [`MMU_NUM_PROCS];

	selT selector;		// Names the running process
	execModeT modeReg;	// Current execution mode

	// Bound registers
	// A write always targets the entry of the process currently selected,
	// so software loads the selector first and then the four bounds
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `MMU_NUM_PROCS; i++) begin
				lowerImTab[i] <= '0;
				upperImTab[i] <= '0;
				lowerDmTab[i] <= '0;
				upperDmTab[i] <= '0;
			end
		end else if (cfg.we) begin
			case (cfg.field)
				lowerIm: lowerImTab[selector] <= cfg.data;
				upperIm: upperImTab[selector] <= cfg.data;
				lowerDm: lowerDmTab[selector] <= cfg.data;
				upperDm: upperDmTab[selector] <= cfg.data;
			endcase
		end
	end

	// Selector register, process 0 runs after reset
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			selector <= '0;
		end else if (selWe) begin
			selector <= selData;	// New bounds are seen from the next cycle on
		end
	end

	// Mode register
	// The system comes out of reset in kernel mode so boot code runs untranslated
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			modeReg <= kernelMode;
		end else if (enterKernel) begin
			modeReg <= kernelMode;	// Checked first so kernel wins a collision
		end else if (enterUser) begin
			modeReg <= userMode;
		end
	end

	// Bounds of the running process go straight to the translators
	always_comb begin
		imBounds.lower = lowerImTab[selector];
		imBounds.upper = upperImTab[selector];
		dmBounds.lower = lowerDmTab[selector];
		dmBounds.upper = upperDmTab[selector];
	end

	assign mode = modeReg;

	// Software must never point the selector past the last entry,
	// otherwise later writes and lookups would address a missing process
	selInRange: assert property (
		@(posedge clk) disable iff (!arstN)
		selWe |-> (selData < `MMU_NUM_PROCS)
	) else $error("Selector write of %0d is outside the table", selData);

	// The sequencer driving the mode pulses issues one change at a time
	modePulsesExclusive: assert property (
		@(posedge clk) disable iff (!arstN)
		!(enterUser && enterKernel)
	) else $error("enterUser and enterKernel pulsed together");

endmodule

// ==== filelist.f ====
+incdir+include
design/mmuPkg.sv
design/segmentTable.sv
design/addressTranslator.sv
design/faultRecorder.sv
design/mmuTop.sv
bench/clockGen.sv
bench/mmuBench.sv

// ==== include/mmu_defs.svh ====
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// Width of a logical or physical address in bits
// Matches the physical address bus of the instruction and data memories
`define MMU_ADDR_W 26

// Number of process entries held in the segment table
`define MMU_NUM_PROCS 11

// Width of the process selector
// Must be wide enough to index every entry of the table
`define MMU_SEL_W 4

`endif

// ==== run.sh ====
#!/bin/sh
# Builds the MMU testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module mmuBench -o mmuSim
./obj_dir/mmuSim 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "TEST OK" sim.log; then
	echo "Simulation ended without a pass message"
	exit 1
fi
echo "Simulation passed"
